// ==== src/credit_pipe_settings.svh ====
`ifndef CREDIT_PIPE_SETTINGS_SVH
`define CREDIT_PIPE_SETTINGS_SVH

// operand and result width, one word
`define CP_DATA_W 16

// edges from acceptance to the fifo write
`define CP_PIPE_LAT 4

// result fifo entries, power of two
`define CP_FIFO_DEPTH 8

`endif

// ==== src/credit_pipe_pkg.sv ====
`default_nettype none

`include "credit_pipe_settings.svh"

package credit_pipe_pkg;

  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_MIN = 2'd2, // unsigned
    OP_MAX = 2'd3  // unsigned
  } op_e;

  typedef logic [`CP_DATA_W-1:0] data_t;

  // must reach CP_FIFO_DEPTH itself, not just depth-1
  localparam int COUNT_W = $clog2(`CP_FIFO_DEPTH + 1);

  typedef logic [COUNT_W-1:0] count_t;

endpackage

`default_nettype wire

// ==== src/issue_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "credit_pipe_settings.svh"

module issue_ctrl (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_valid,
  input  credit_pipe_pkg::count_t fifo_count,
  output logic                    accept,
  output logic                    in_stall,
  output logic                    wr_en
);

  localparam int CNT_W = $bits(credit_pipe_pkg::count_t);

  logic [`CP_PIPE_LAT-1:0] valid_line; // bit 0 is the newest slot
  credit_pipe_pkg::count_t in_flight;
  credit_pipe_pkg::count_t in_flight_next;
  logic [CNT_W:0]          credit_used; // spare top bit for the sum

  assign accept = in_valid & ~in_stall;

  // tail of the line lines up with the last alu stage
  assign wr_en = valid_line[`CP_PIPE_LAT-1];

  // results already stored plus results still on their way
  assign credit_used = {1'b0, in_flight} + {1'b0, fifo_count};
  assign in_stall    = (credit_used >= (CNT_W + 1)'(`CP_FIFO_DEPTH));

  always_comb begin
    case ({accept, wr_en})
      2'b10:   in_flight_next = in_flight + 1'b1;
      2'b01:   in_flight_next = in_flight - 1'b1;
      default: in_flight_next = in_flight; // idle, or one in and one out
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      valid_line <= '0;
      in_flight  <= '0;
    end else begin
      valid_line <= {valid_line[`CP_PIPE_LAT-2:0], accept};
      in_flight  <= in_flight_next;
    end
  end

endmodule

`default_nettype wire

// ==== src/alu_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "credit_pipe_settings.svh"

module alu_pipe (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   accept,
  input  credit_pipe_pkg::op_e   op,
  input  credit_pipe_pkg::data_t a,
  input  credit_pipe_pkg::data_t b,
  output credit_pipe_pkg::data_t res_data,
  output logic                   res_zero,
  output logic                   res_neg
);

  localparam int DW     = $bits(credit_pipe_pkg::data_t);
  localparam int SLOT_W = DW + 2; // zero, neg, data

  credit_pipe_pkg::data_t sum;
  credit_pipe_pkg::data_t diff;
  credit_pipe_pkg::data_t result;
  logic                   a_lt_b;
  logic                   zero_flag;
  logic                   neg_flag;
  logic [SLOT_W-1:0]      head_slot;

  logic [`CP_PIPE_LAT-1:0][SLOT_W-1:0] stage;

  assign sum    = a + b;
  assign diff   = a - b; // wraps when b > a
  assign a_lt_b = (a < b);

  always_comb begin
    case (op)
      credit_pipe_pkg::OP_ADD: result = sum;
      credit_pipe_pkg::OP_SUB: result = diff;
      credit_pipe_pkg::OP_MIN: result = a_lt_b ? a : b;
      credit_pipe_pkg::OP_MAX: result = a_lt_b ? b : a; // equal operands give a
      default:                 result = '0;
    endcase
  end

  assign zero_flag = (result == '0);
  assign neg_flag  = result[DW-1];

  // empty slots carry zeros, wr_en masks them at the fifo
  assign head_slot = accept ? {zero_flag, neg_flag, result} : '0;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      stage <= '0;
    end else begin
      stage <= {stage[`CP_PIPE_LAT-2:0], head_slot};
    end
  end

  // last stage
  assign res_data = stage[`CP_PIPE_LAT-1][DW-1:0];
  assign res_neg  = stage[`CP_PIPE_LAT-1][DW];
  assign res_zero = stage[`CP_PIPE_LAT-1][DW+1];

endmodule

`default_nettype wire

// ==== src/result_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "credit_pipe_settings.svh"

module result_fifo (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    wr_en,
  input  credit_pipe_pkg::data_t  wr_data,
  input  logic                    wr_zero,
  input  logic                    wr_neg,
  input  logic                    rd_en,
  output credit_pipe_pkg::data_t  rd_data,
  output logic                    rd_zero,
  output logic                    rd_neg,
  output logic                    empty,
  output logic                    full,
  output credit_pipe_pkg::count_t count
);

  localparam int PTR_W = $clog2(`CP_FIFO_DEPTH);

  credit_pipe_pkg::data_t data_mem [`CP_FIFO_DEPTH];
  logic                   zero_mem [`CP_FIFO_DEPTH];
  logic                   neg_mem  [`CP_FIFO_DEPTH];

  logic [PTR_W-1:0]        wr_ptr;
  logic [PTR_W-1:0]        rd_ptr;
  logic [PTR_W-1:0]        wr_ptr_next;
  logic [PTR_W-1:0]        rd_ptr_next;
  credit_pipe_pkg::count_t count_next;
  logic                    wr_ok;
  logic                    rd_ok;

  assign empty = (count == '0);
  assign full  = (count == credit_pipe_pkg::count_t'(`CP_FIFO_DEPTH));

  // overflow and underflow are dropped here
  assign wr_ok = wr_en & ~full;
  assign rd_ok = rd_en & ~empty;

  always_comb begin
    wr_ptr_next = wr_ptr;
    rd_ptr_next = rd_ptr;
    if (wr_ok) begin
      wr_ptr_next = (wr_ptr == PTR_W'(`CP_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
    end
    if (rd_ok) begin
      rd_ptr_next = (rd_ptr == PTR_W'(`CP_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
    end
  end

  always_comb begin
    case ({wr_ok, rd_ok})
      2'b10:   count_next = count + 1'b1;
      2'b01:   count_next = count - 1'b1;
      default: count_next = count; // push and pop cancel
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr_next;
      rd_ptr <= rd_ptr_next;
      count  <= count_next;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      data_mem[wr_ptr] <= wr_data;
      zero_mem[wr_ptr] <= wr_zero;
      neg_mem[wr_ptr]  <= wr_neg;
    end
  end

  // fall-through head
  assign rd_data = data_mem[rd_ptr];
  assign rd_zero = zero_mem[rd_ptr];
  assign rd_neg  = neg_mem[rd_ptr];

endmodule

`default_nettype wire

// ==== src/credit_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module credit_pipe (
  input  logic                    clk,
  input  logic                    rst,

  // request side
  input  logic                    in_valid,
  input  credit_pipe_pkg::op_e    in_op,
  input  credit_pipe_pkg::data_t  in_a,
  input  credit_pipe_pkg::data_t  in_b,
  output logic                    in_stall,

  // result side
  input  logic                    rd_en,
  output credit_pipe_pkg::data_t  out_data,
  output logic                    out_zero,
  output logic                    out_neg,
  output logic                    empty,
  output logic                    full,
  output credit_pipe_pkg::count_t count
);

  logic                   accept;
  logic                   wr_en;
  credit_pipe_pkg::data_t res_data;
  logic                   res_zero;
  logic                   res_neg;

  // credit check against fifo occupancy
  issue_ctrl issue_ctrl_i (
    .clk,
    .rst,
    .in_valid,
    .fifo_count (count),
    .accept,
    .in_stall,
    .wr_en
  );

  alu_pipe alu_pipe_i (
    .clk,
    .rst,
    .accept,
    .op       (in_op),
    .a        (in_a),
    .b        (in_b),
    .res_data,
    .res_zero,
    .res_neg
  );

  result_fifo result_fifo_i (
    .clk,
    .rst,
    .wr_en,
    .wr_data  (res_data),
    .wr_zero  (res_zero),
    .wr_neg   (res_neg),
    .rd_en,
    .rd_data  (out_data),
    .rd_zero  (out_zero),
    .rd_neg   (out_neg),
    .empty,
    .full,
    .count
  );

endmodule

`default_nettype wire

// ==== dv/tb_credit_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "credit_pipe_settings.svh"

module tb_credit_pipe;

  localparam int TIMEOUT = 200; // cycles allowed for any single wait
  localparam int DW      = `CP_DATA_W;

  logic                    clk;
  logic                    rst;
  logic                    in_valid;
  credit_pipe_pkg::op_e    in_op;
  credit_pipe_pkg::data_t  in_a;
  credit_pipe_pkg::data_t  in_b;
  logic                    rd_en;
  logic                    in_stall;
  credit_pipe_pkg::data_t  out_data;
  logic                    out_zero;
  logic                    out_neg;
  logic                    empty;
  logic                    full;
  credit_pipe_pkg::count_t count;

  // expected results, oldest first
  credit_pipe_pkg::data_t exp_data [$];
  logic                   exp_zero [$];
  logic                   exp_neg  [$];

  // acceptance edge of each request that may still be in the pipe
  int accept_edge [$];

  int    accept_total;
  int    read_total;
  int    edge_total; // rising edges seen so far
  int    err_data;
  int    err_flag;
  int    err_count;
  int    err_number;
  int    err_other;
  string test_name;

  credit_pipe credit_pipe_i (
    .clk,
    .rst,
    .in_valid,
    .in_op,
    .in_a,
    .in_b,
    .in_stall,
    .rd_en,
    .out_data,
    .out_zero,
    .out_neg,
    .empty,
    .full,
    .count
  );

  always #10 clk = ~clk;

  always @(posedge clk) edge_total++;

  function automatic credit_pipe_pkg::data_t expect_result(credit_pipe_pkg::op_e op,
                                                           credit_pipe_pkg::data_t a,
                                                           credit_pipe_pkg::data_t b);
    credit_pipe_pkg::data_t r;
    case (op)
      credit_pipe_pkg::OP_ADD: r = a + b;
      credit_pipe_pkg::OP_SUB: r = a - b; // modulo 2**DW
      credit_pipe_pkg::OP_MIN: r = (a <= b) ? a : b;
      default:                 r = (a >= b) ? a : b;
    endcase
    return r;
  endfunction

  function automatic credit_pipe_pkg::op_e random_op();
    return credit_pipe_pkg::op_e'($urandom % 4);
  endfunction

  function automatic credit_pipe_pkg::data_t random_word();
    return credit_pipe_pkg::data_t'($urandom);
  endfunction

  task automatic check_data(string what, credit_pipe_pkg::data_t exp,
                            credit_pipe_pkg::data_t act);
    if (act !== exp) begin
      err_data++;
      $display("error %s %s: expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_flag(string what, logic exp, logic act);
    if (act !== exp) begin
      err_flag++;
      $display("error %s %s: expected %b actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic check_count(string what, credit_pipe_pkg::count_t exp,
                             credit_pipe_pkg::count_t act);
    if (act !== exp) begin
      err_count++;
      $display("error %s %s: expected %0d actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic check_number(string what, int exp, int act);
    if (act != exp) begin
      err_number++;
      $display("error %s %s: expected %0d actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic report_timeout(string what);
    err_other++;
    $display("%s: gave up after %0d cycles waiting for %s", test_name, TIMEOUT, what);
  endtask

  // stored results plus accepted ones still in the pipe
  task automatic check_credit();
    int in_flight;
    // written CP_PIPE_LAT edges after acceptance
    while (accept_edge.size() > 0 && accept_edge[0] + `CP_PIPE_LAT <= edge_total) begin
      accept_edge.delete(0);
    end
    in_flight = accept_edge.size();
    if (int'(count) + in_flight > `CP_FIFO_DEPTH) begin
      err_other++;
      $display("%s: %0d stored plus %0d in flight is more than the fifo holds",
               test_name, count, in_flight);
    end
  endtask

  // called and returns just after a falling edge
  task automatic send_request(credit_pipe_pkg::op_e op, credit_pipe_pkg::data_t a,
                              credit_pipe_pkg::data_t b);
    int                     waited;
    credit_pipe_pkg::data_t r;
    waited   = 0;
    in_valid = 1'b1;
    in_op    = op;
    in_a     = a;
    in_b     = b;
    while (in_stall && waited < TIMEOUT) begin // stall only moves on rising edges
      @(negedge clk);
      waited++;
    end
    if (in_stall) begin
      report_timeout("in_stall to fall");
      in_valid = 1'b0;
    end else begin
      r = expect_result(op, a, b);
      exp_data.push_back(r);
      exp_zero.push_back(r == '0);
      exp_neg.push_back(r[DW-1]);
      accept_edge.push_back(edge_total + 1);
      accept_total++;
      @(negedge clk); // taken on the edge in between
      in_valid = 1'b0;
    end
  endtask

  task automatic read_result();
    int waited;
    waited = 0;
    while (empty && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (empty) begin
      report_timeout("a result in the fifo");
    end else begin
      if (exp_data.size() == 0) begin
        err_other++;
        $display("%s: fifo holds a result that no accepted request explains", test_name);
      end else begin
        check_data("out_data", exp_data.pop_front(), out_data);
        check_flag("out_zero", exp_zero.pop_front(), out_zero);
        check_flag("out_neg", exp_neg.pop_front(), out_neg);
      end
      rd_en = 1'b1;
      @(negedge clk);
      rd_en = 1'b0;
      read_total++;
    end
  endtask

  task automatic test_reset_state();
    test_name = "reset_state";
    check_flag("empty", 1'b1, empty);
    check_flag("full", 1'b0, full);
    check_flag("in_stall", 1'b0, in_stall);
    check_count("count", '0, count);
  endtask

  task automatic run_single(credit_pipe_pkg::op_e op, credit_pipe_pkg::data_t a,
                            credit_pipe_pkg::data_t b);
    send_request(op, a, b);
    read_result();
  endtask

  task automatic test_opcodes();
    test_name = "opcodes";
    run_single(credit_pipe_pkg::OP_ADD, 16'h1234, 16'h0f0f);
    run_single(credit_pipe_pkg::OP_ADD, 16'hffff, 16'h0001); // wraps to zero
    run_single(credit_pipe_pkg::OP_SUB, 16'h0005, 16'h0009); // underflow
    run_single(credit_pipe_pkg::OP_SUB, 16'h7777, 16'h7777);
    run_single(credit_pipe_pkg::OP_MIN, 16'h8000, 16'h0001);
    run_single(credit_pipe_pkg::OP_MIN, 16'h00aa, 16'h00aa);
    run_single(credit_pipe_pkg::OP_MAX, 16'h00ff, 16'hff00);
    run_single(credit_pipe_pkg::OP_MAX, 16'h4321, 16'h4321);
  endtask

  task automatic test_fixed_latency();
    int edges;
    test_name = "fixed_latency";
    check_flag("empty before request", 1'b1, empty);
    send_request(credit_pipe_pkg::OP_ADD, 16'h0100, 16'h0023);
    edges = 0; // edges counted from the acceptance edge
    while (empty && edges < TIMEOUT) begin
      @(negedge clk);
      edges++;
    end
    if (empty) begin
      report_timeout("empty to fall");
    end else begin
      check_number("edges until empty low", `CP_PIPE_LAT, edges);
    end
    read_result();
  endtask

  task automatic test_streaming();
    test_name = "streaming";
    fork
      begin
        for (int i = 0; i < 40; i++) begin
          send_request(random_op(), random_word(), random_word());
        end
      end
      begin
        for (int j = 0; j < 40; j++) begin
          read_result();
        end
      end
    join
    check_flag("empty after stream", 1'b1, empty);
    check_number("results left in model", 0, exp_data.size());
  endtask

  task automatic test_backpressure();
    int offers;
    int held;
    test_name = "backpressure";
    rd_en  = 1'b0;
    offers = 0;
    while (!in_stall && offers < 4 * `CP_FIFO_DEPTH) begin
      send_request(random_op(), random_word(), random_word());
      check_credit();
      offers++;
    end
    check_flag("in_stall after filling", 1'b1, in_stall);
    check_number("accepted before stall", `CP_FIFO_DEPTH, accept_total - read_total);
    // keep offering while stalled, nothing may be taken
    in_valid = 1'b1;
    in_op    = random_op();
    in_a     = random_word();
    in_b     = random_word();
    held     = 0;
    while (!full && held < TIMEOUT) begin
      check_credit();
      check_flag("in_stall while filling", 1'b1, in_stall);
      @(negedge clk);
      held++;
    end
    if (!full) begin
      report_timeout("full to rise");
    end
    repeat (`CP_PIPE_LAT) begin
      @(negedge clk);
      check_credit();
    end
    in_valid = 1'b0;
    check_count("count when full", credit_pipe_pkg::count_t'(`CP_FIFO_DEPTH), count);
    repeat (`CP_FIFO_DEPTH) begin
      read_result();
    end
    check_flag("empty after drain", 1'b1, empty);
    check_flag("in_stall after drain", 1'b0, in_stall);
    check_number("results left in model", 0, exp_data.size());
  endtask

  task automatic test_read_empty();
    test_name = "read_empty";
    check_flag("empty before reads", 1'b1, empty);
    rd_en = 1'b1;
    repeat (3) begin
      @(negedge clk);
      check_count("count", '0, count);
      check_flag("empty", 1'b1, empty);
    end
    rd_en = 1'b0;
    send_request(credit_pipe_pkg::OP_SUB, 16'h0010, 16'h0003);
    read_result();
    check_count("count after read", '0, count);
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    in_valid     = 1'b0;
    in_op        = credit_pipe_pkg::OP_ADD;
    in_a         = '0;
    in_b         = '0;
    rd_en        = 1'b0;
    accept_total = 0;
    read_total   = 0;
    edge_total   = 0;
    err_data     = 0;
    err_flag     = 0;
    err_count    = 0;
    err_number   = 0;
    err_other    = 0;
    test_name    = "init";
    void'($urandom(40166));

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_reset_state();
    test_opcodes();
    test_fixed_latency();
    test_streaming();
    test_backpressure();
    test_read_empty();

    $display("errors: data %0d, flag %0d, count %0d, number %0d, other %0d",
             err_data, err_flag, err_count, err_number, err_other);
    if (err_data + err_flag + err_count + err_number + err_other == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== credit_pipe.f ====
+incdir+src
src/credit_pipe_pkg.sv
src/issue_ctrl.sv
src/alu_pipe.sv
src/result_fifo.sv
src/credit_pipe.sv
dv/tb_credit_pipe.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the credit_pipe testbench with verilator
set -e
cd "$(dirname "$0")"

log=sim.log

verilator --binary --timing --timescale 1ns/1ps \
  -f credit_pipe.f \
  --top-module tb_credit_pipe \
  -o tb_credit_pipe

./obj_dir/tb_credit_pipe > "$log" 2>&1
cat "$log"

if grep -q "SIMULATION FAILED" "$log"; then
  echo "simulation reported failure, see $log"
  exit 1
fi
if ! grep -q "SIMULATION PASSED" "$log"; then
  echo "simulation ended without a result line, see $log"
  exit 1
fi
